// ==== common/fpga_sys_pkg.sv ====
// fpga_sys_pkg
// shared widths, LED register map and memory command codes for the
// memory-access side of the RV32I FPGA system

package fpga_sys_pkg;

	// line path
	localparam int LINE_W = 128; // one cache line
	localparam int MASK_W = 16; // one mask bit per byte, set keeps old byte
	localparam int ADDR_W = 32; // byte address
	localparam int LINE_OFS = 4; // byte offset bits inside a line
	localparam int LINE_IDX_W = ADDR_W - LINE_OFS; // line index carried to memory

	// dma i/o register bus
	localparam int IO_AW = 14; // word address, byte bits 15:2
	localparam int IO_DW = 32;

	// rgb led registers
	localparam int LED_W = 3;
	localparam logic [IO_AW-1:0] LED_BASE = 14'h3f80; // four words from here

	// memory command
	typedef enum logic {
		CMD_READ = 1'b0,
		CMD_WRITE = 1'b1
	} cmd_e;

	// owner of a bus grant
	typedef enum logic {
		MST_UART = 1'b0,
		MST_DC = 1'b1
	} master_e;

endpackage

// ==== hw/axi_bus/bus_arbiter.sv ====
// bus_arbiter
// serializes the uart loader and dcache line masters onto one memory
// command port. strobes are latched per master, ties go round robin,
// and each done pulse is routed back to the master that owns the grant

`timescale 1ns/100ps

module bus_arbiter (
	input logic i_clk,
	input logic i_rst_n,
	// uart loader master
	input logic i_uart_wstart_rq,
	input logic i_uart_rstart_rq,
	input logic [fpga_sys_pkg::ADDR_W-1:0] i_uart_win_addr,
	input logic [fpga_sys_pkg::ADDR_W-1:0] i_uart_rin_addr,
	input logic [fpga_sys_pkg::LINE_W-1:0] i_uart_in_wdata,
	input logic [fpga_sys_pkg::MASK_W-1:0] i_uart_in_mask,
	output logic o_uart_finish_wresp,
	output logic o_uart_finish_mrd,
	output logic o_uart_rdat_m_valid,
	output logic [fpga_sys_pkg::LINE_W-1:0] o_uart_rdat_m_data,
	// dcache refill / write-back master
	input logic i_dc_wstart_rq,
	input logic i_dc_rstart_rq,
	input logic [fpga_sys_pkg::ADDR_W-1:0] i_dc_win_addr,
	input logic [fpga_sys_pkg::ADDR_W-1:0] i_dc_rin_addr,
	input logic [fpga_sys_pkg::LINE_W-1:0] i_dc_in_wdata,
	input logic [fpga_sys_pkg::MASK_W-1:0] i_dc_in_mask,
	output logic o_dc_finish_wresp,
	output logic o_dc_finish_mrd,
	output logic o_dc_rdat_m_valid,
	output logic [fpga_sys_pkg::LINE_W-1:0] o_dc_rdat_m_data,
	output logic o_dc_rqfull,
	// memory command port
	output logic o_cmd_valid,
	output fpga_sys_pkg::cmd_e o_cmd_type,
	output logic [fpga_sys_pkg::LINE_IDX_W-1:0] o_cmd_line,
	output logic [fpga_sys_pkg::LINE_W-1:0] o_cmd_wdata,
	output logic [fpga_sys_pkg::MASK_W-1:0] o_cmd_mask,
	input logic i_wr_done,
	input logic i_rd_valid,
	input logic [fpga_sys_pkg::LINE_W-1:0] i_rd_data
);

logic uart_pend; // uart request waiting for a grant
logic dc_pend;
fpga_sys_pkg::cmd_e uart_type;
fpga_sys_pkg::cmd_e dc_type;
logic busy; // one command in flight
fpga_sys_pkg::master_e owner; // current grant, also the last one served
fpga_sys_pkg::master_e gnt;
logic [fpga_sys_pkg::ADDR_W-1:0] gnt_addr;
logic dc_out; // dc request outstanding
logic uart_sel;
logic dc_sel;

// request latches, one per master
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		uart_pend <= 1'b0;
		uart_type <= fpga_sys_pkg::CMD_READ;
		dc_pend <= 1'b0;
		dc_type <= fpga_sys_pkg::CMD_READ;
	end else begin
		if (i_uart_wstart_rq | i_uart_rstart_rq) begin
			uart_pend <= 1'b1;
			uart_type <= i_uart_wstart_rq ? fpga_sys_pkg::CMD_WRITE : fpga_sys_pkg::CMD_READ;
		end else if (o_cmd_valid & (gnt == fpga_sys_pkg::MST_UART)) begin
			uart_pend <= 1'b0; // handed to memory
		end
		if (i_dc_wstart_rq | i_dc_rstart_rq) begin
			dc_pend <= 1'b1;
			dc_type <= i_dc_wstart_rq ? fpga_sys_pkg::CMD_WRITE : fpga_sys_pkg::CMD_READ;
		end else if (o_cmd_valid & (gnt == fpga_sys_pkg::MST_DC)) begin
			dc_pend <= 1'b0;
		end
	end
end

// round robin, the master not served last wins a tie
always_comb begin
	if (uart_pend & dc_pend)
		gnt = (owner == fpga_sys_pkg::MST_UART) ? fpga_sys_pkg::MST_DC : fpga_sys_pkg::MST_UART;
	else if (dc_pend)
		gnt = fpga_sys_pkg::MST_DC;
	else
		gnt = fpga_sys_pkg::MST_UART;
end

assign o_cmd_valid = ~busy & (uart_pend | dc_pend);

// command fields from the granted master's held inputs
always_comb begin
	if (gnt == fpga_sys_pkg::MST_DC) begin
		o_cmd_type = dc_type;
		gnt_addr = (dc_type == fpga_sys_pkg::CMD_WRITE) ? i_dc_win_addr : i_dc_rin_addr;
		o_cmd_wdata = i_dc_in_wdata;
		o_cmd_mask = i_dc_in_mask;
	end else begin
		o_cmd_type = uart_type;
		gnt_addr = (uart_type == fpga_sys_pkg::CMD_WRITE) ? i_uart_win_addr : i_uart_rin_addr;
		o_cmd_wdata = i_uart_in_wdata;
		o_cmd_mask = i_uart_in_mask;
	end
end

assign o_cmd_line = gnt_addr[fpga_sys_pkg::ADDR_W-1:fpga_sys_pkg::LINE_OFS]; // drop byte offset

// grant state
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		busy <= 1'b0;
		owner <= fpga_sys_pkg::MST_DC; // uart wins the first tie
	end else if (o_cmd_valid) begin
		busy <= 1'b1;
		owner <= gnt;
	end else if (i_wr_done | i_rd_valid) begin
		busy <= 1'b0;
	end
end

// dc request full flag, held through the finish cycle
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n)
		dc_out <= 1'b0;
	else if (i_dc_wstart_rq | i_dc_rstart_rq)
		dc_out <= 1'b1;
	else if (o_dc_finish_wresp | o_dc_finish_mrd)
		dc_out <= 1'b0;
end

assign o_dc_rqfull = dc_out;

// completion steering
assign uart_sel = busy & (owner == fpga_sys_pkg::MST_UART);
assign dc_sel = busy & (owner == fpga_sys_pkg::MST_DC);

assign o_uart_finish_wresp = i_wr_done & uart_sel;
assign o_uart_finish_mrd = i_rd_valid & uart_sel;
assign o_uart_rdat_m_valid = i_rd_valid & uart_sel; // pairs with finish_mrd
assign o_uart_rdat_m_data = uart_sel ? i_rd_data : '0;

assign o_dc_finish_wresp = i_wr_done & dc_sel;
assign o_dc_finish_mrd = i_rd_valid & dc_sel;
assign o_dc_rdat_m_valid = i_rd_valid & dc_sel;
assign o_dc_rdat_m_data = dc_sel ? i_rd_data : '0;

endmodule

// ==== hw/dram/line_mem_ctrl.sv ====
// line_mem_ctrl
// on-chip line memory in place of the DRAM path. byte-masked line
// writes finish after 2 cycles, line reads after RD_LAT cycles

`timescale 1ns/100ps

module line_mem_ctrl #(
	parameter int MEM_AW = 6, // line index bits kept
	parameter int RD_LAT = 4 // read latency, 2 or more
) (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_cmd_valid,
	input fpga_sys_pkg::cmd_e i_cmd_type,
	input logic [fpga_sys_pkg::LINE_IDX_W-1:0] i_cmd_line,
	input logic [fpga_sys_pkg::LINE_W-1:0] i_cmd_wdata,
	input logic [fpga_sys_pkg::MASK_W-1:0] i_cmd_mask,
	output logic o_wr_done,
	output logic o_rd_valid,
	output logic [fpga_sys_pkg::LINE_W-1:0] o_rd_data
);

localparam int MEM_DEPTH = 1 << MEM_AW;

logic [fpga_sys_pkg::LINE_W-1:0] mem_array [0:MEM_DEPTH-1];
logic [MEM_AW-1:0] idx;
logic wr_cmd;
logic rd_cmd;
logic [1:0] wr_pipe; // write done delay
logic [RD_LAT-1:0] rd_pipe; // read valid delay
logic [fpga_sys_pkg::LINE_W-1:0] rd_q;

// upper index bits ignored, addresses wrap over the array
assign idx = i_cmd_line[MEM_AW-1:0];

assign wr_cmd = i_cmd_valid & (i_cmd_type == fpga_sys_pkg::CMD_WRITE);
assign rd_cmd = i_cmd_valid & (i_cmd_type == fpga_sys_pkg::CMD_READ);

// line array
// a clear mask bit writes that byte, a set bit keeps the stored one
always_ff @(posedge i_clk) begin
	if (wr_cmd) begin
		for (int b = 0; b < fpga_sys_pkg::MASK_W; b++) begin
			if (!i_cmd_mask[b])
				mem_array[idx][b*8 +: 8] <= i_cmd_wdata[b*8 +: 8];
		end
	end
end

// read data register
// holds until rd_valid since only one command is in flight
always_ff @(posedge i_clk) begin
	if (rd_cmd)
		rd_q <= mem_array[idx];
end

// completion timing
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		wr_pipe <= 2'b00;
		rd_pipe <= '0;
	end else begin
		wr_pipe <= {wr_pipe[0], wr_cmd};
		rd_pipe <= {rd_pipe[RD_LAT-2:0], rd_cmd};
	end
end

assign o_wr_done = wr_pipe[1]; // 2 cycles after the command
assign o_rd_valid = rd_pipe[RD_LAT-1]; // RD_LAT cycles after the command
assign o_rd_data = rd_q;

endmodule

// ==== hw/io_led.sv ====
// io_led
// four rgb led registers on the dma i/o bus
// reads outside the led window pass the downstream chain data through

`timescale 1ns/100ps

module io_led (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_dma_io_we,
	input logic [fpga_sys_pkg::IO_AW-1:0] i_dma_io_wadr,
	input logic [fpga_sys_pkg::IO_DW-1:0] i_dma_io_wdata,
	input logic [fpga_sys_pkg::IO_AW-1:0] i_dma_io_radr,
	input logic [fpga_sys_pkg::IO_DW-1:0] i_dma_io_rdata_in,
	output logic [fpga_sys_pkg::IO_DW-1:0] o_dma_io_rdata,
	output logic [fpga_sys_pkg::LED_W-1:0] o_rgb_led,
	output logic [fpga_sys_pkg::LED_W-1:0] o_rgb_led1,
	output logic [fpga_sys_pkg::LED_W-1:0] o_rgb_led2,
	output logic [fpga_sys_pkg::LED_W-1:0] o_rgb_led3
);

logic [fpga_sys_pkg::LED_W-1:0] led_q [0:3];
logic wr_hit;
logic rd_hit;
logic [fpga_sys_pkg::IO_DW-1:0] rdata_q;

// window is 4 words, LED_BASE word aligned to 4
assign wr_hit = i_dma_io_we &
	(i_dma_io_wadr[fpga_sys_pkg::IO_AW-1:2] == fpga_sys_pkg::LED_BASE[fpga_sys_pkg::IO_AW-1:2]);
assign rd_hit =
	(i_dma_io_radr[fpga_sys_pkg::IO_AW-1:2] == fpga_sys_pkg::LED_BASE[fpga_sys_pkg::IO_AW-1:2]);

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		for (int i = 0; i < 4; i++)
			led_q[i] <= '0; // leds off
	end else if (wr_hit) begin
		led_q[i_dma_io_wadr[1:0]] <= i_dma_io_wdata[fpga_sys_pkg::LED_W-1:0];
	end
end

// registered readback, chain data when not ours
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n)
		rdata_q <= '0;
	else if (rd_hit)
		rdata_q <= {{(fpga_sys_pkg::IO_DW-fpga_sys_pkg::LED_W){1'b0}},
			led_q[i_dma_io_radr[1:0]]};
	else
		rdata_q <= i_dma_io_rdata_in;
end

assign o_dma_io_rdata = rdata_q;

assign o_rgb_led = led_q[0];
assign o_rgb_led1 = led_q[1];
assign o_rgb_led2 = led_q[2];
assign o_rgb_led3 = led_q[3];

endmodule

// ==== hw/fpga_sys_top.sv ====
// fpga_sys_top
// memory-access side of the RV32I FPGA system: bus arbiter for the
// uart loader and dcache masters, on-chip line memory, rgb led i/o

`timescale 1ns/100ps

module fpga_sys_top #(
	parameter int MEM_AW = 6,
	parameter int RD_LAT = 4
) (
	input logic i_clk,
	input logic i_rst_n,
	// uart loader master
	input logic i_uart_wstart_rq,
	input logic i_uart_rstart_rq,
	input logic [fpga_sys_pkg::ADDR_W-1:0] i_uart_win_addr,
	input logic [fpga_sys_pkg::ADDR_W-1:0] i_uart_rin_addr,
	input logic [fpga_sys_pkg::LINE_W-1:0] i_uart_in_wdata,
	input logic [fpga_sys_pkg::MASK_W-1:0] i_uart_in_mask,
	output logic o_uart_finish_wresp,
	output logic o_uart_finish_mrd,
	output logic o_uart_rdat_m_valid,
	output logic [fpga_sys_pkg::LINE_W-1:0] o_uart_rdat_m_data,
	// dcache master
	input logic i_dc_wstart_rq,
	input logic i_dc_rstart_rq,
	input logic [fpga_sys_pkg::ADDR_W-1:0] i_dc_win_addr,
	input logic [fpga_sys_pkg::ADDR_W-1:0] i_dc_rin_addr,
	input logic [fpga_sys_pkg::LINE_W-1:0] i_dc_in_wdata,
	input logic [fpga_sys_pkg::MASK_W-1:0] i_dc_in_mask,
	output logic o_dc_finish_wresp,
	output logic o_dc_finish_mrd,
	output logic o_dc_rdat_m_valid,
	output logic [fpga_sys_pkg::LINE_W-1:0] o_dc_rdat_m_data,
	output logic o_dc_rqfull,
	// dma i/o bus
	input logic i_dma_io_we,
	input logic [fpga_sys_pkg::IO_AW-1:0] i_dma_io_wadr,
	input logic [fpga_sys_pkg::IO_DW-1:0] i_dma_io_wdata,
	input logic [fpga_sys_pkg::IO_AW-1:0] i_dma_io_radr,
	input logic [fpga_sys_pkg::IO_DW-1:0] i_dma_io_rdata_in,
	output logic [fpga_sys_pkg::IO_DW-1:0] o_dma_io_rdata,
	// leds
	output logic [fpga_sys_pkg::LED_W-1:0] o_rgb_led,
	output logic [fpga_sys_pkg::LED_W-1:0] o_rgb_led1,
	output logic [fpga_sys_pkg::LED_W-1:0] o_rgb_led2,
	output logic [fpga_sys_pkg::LED_W-1:0] o_rgb_led3
);

// arbiter to line memory
logic cmd_valid;
fpga_sys_pkg::cmd_e cmd_type;
logic [fpga_sys_pkg::LINE_IDX_W-1:0] cmd_line;
logic [fpga_sys_pkg::LINE_W-1:0] cmd_wdata;
logic [fpga_sys_pkg::MASK_W-1:0] cmd_mask;
logic wr_done;
logic rd_valid;
logic [fpga_sys_pkg::LINE_W-1:0] rd_data;

bus_arbiter u_arb (
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.i_uart_wstart_rq(i_uart_wstart_rq),
	.i_uart_rstart_rq(i_uart_rstart_rq),
	.i_uart_win_addr(i_uart_win_addr),
	.i_uart_rin_addr(i_uart_rin_addr),
	.i_uart_in_wdata(i_uart_in_wdata),
	.i_uart_in_mask(i_uart_in_mask),
	.o_uart_finish_wresp(o_uart_finish_wresp),
	.o_uart_finish_mrd(o_uart_finish_mrd),
	.o_uart_rdat_m_valid(o_uart_rdat_m_valid),
	.o_uart_rdat_m_data(o_uart_rdat_m_data),
	.i_dc_wstart_rq(i_dc_wstart_rq),
	.i_dc_rstart_rq(i_dc_rstart_rq),
	.i_dc_win_addr(i_dc_win_addr),
	.i_dc_rin_addr(i_dc_rin_addr),
	.i_dc_in_wdata(i_dc_in_wdata),
	.i_dc_in_mask(i_dc_in_mask),
	.o_dc_finish_wresp(o_dc_finish_wresp),
	.o_dc_finish_mrd(o_dc_finish_mrd),
	.o_dc_rdat_m_valid(o_dc_rdat_m_valid),
	.o_dc_rdat_m_data(o_dc_rdat_m_data),
	.o_dc_rqfull(o_dc_rqfull),
	.o_cmd_valid(cmd_valid),
	.o_cmd_type(cmd_type),
	.o_cmd_line(cmd_line),
	.o_cmd_wdata(cmd_wdata),
	.o_cmd_mask(cmd_mask),
	.i_wr_done(wr_done),
	.i_rd_valid(rd_valid),
	.i_rd_data(rd_data)
);

line_mem_ctrl #(.MEM_AW(MEM_AW), .RD_LAT(RD_LAT)) u_mem (
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.i_cmd_valid(cmd_valid),
	.i_cmd_type(cmd_type),
	.i_cmd_line(cmd_line),
	.i_cmd_wdata(cmd_wdata),
	.i_cmd_mask(cmd_mask),
	.o_wr_done(wr_done),
	.o_rd_valid(rd_valid),
	.o_rd_data(rd_data)
);

io_led u_led (
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.i_dma_io_we(i_dma_io_we),
	.i_dma_io_wadr(i_dma_io_wadr),
	.i_dma_io_wdata(i_dma_io_wdata),
	.i_dma_io_radr(i_dma_io_radr),
	.i_dma_io_rdata_in(i_dma_io_rdata_in),
	.o_dma_io_rdata(o_dma_io_rdata),
	.o_rgb_led(o_rgb_led),
	.o_rgb_led1(o_rgb_led1),
	.o_rgb_led2(o_rgb_led2),
	.o_rgb_led3(o_rgb_led3)
);

endmodule

// ==== verification/fpga_sys_assertions.sv ====
// fpga_sys_assertions
// protocol checks bound into the bus arbiter
// one command in flight, one-cycle finish pulses and one owner per pulse

`timescale 1ns/100ps

module fpga_sys_assertions (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_cmd_valid,
	input fpga_sys_pkg::cmd_e i_cmd_type,
	input logic i_uart_finish_wresp,
	input logic i_uart_finish_mrd,
	input logic i_dc_finish_wresp,
	input logic i_dc_finish_mrd
);

int fail_count = 0; // read by the testbench summary
logic inflight;
fpga_sys_pkg::cmd_e cur_type;
logic uart_fin;
logic dc_fin;

assign uart_fin = i_uart_finish_wresp | i_uart_finish_mrd;
assign dc_fin = i_dc_finish_wresp | i_dc_finish_mrd;

// command in flight from issue until its master sees the finish
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		inflight <= 1'b0;
		cur_type <= fpga_sys_pkg::CMD_READ;
	end else if (i_cmd_valid) begin
		inflight <= 1'b1;
		cur_type <= i_cmd_type;
	end else if (uart_fin | dc_fin) begin
		inflight <= 1'b0;
	end
end

a_one_cmd: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	i_cmd_valid |-> !inflight)
	else begin fail_count++; $error("command issued while another is in flight"); end
a_uart_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	uart_fin |=> !uart_fin)
	else begin fail_count++; $error("uart finish pulse longer than one cycle"); end
a_dc_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	dc_fin |=> !dc_fin)
	else begin fail_count++; $error("dc finish pulse longer than one cycle"); end
a_one_owner: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	!(uart_fin && dc_fin))
	else begin fail_count++; $error("finish pulses to both masters in one cycle"); end
a_wr_kind: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	(i_uart_finish_wresp | i_dc_finish_wresp) |-> cur_type == fpga_sys_pkg::CMD_WRITE)
	else begin fail_count++; $error("write finish for a read command"); end

endmodule

bind bus_arbiter fpga_sys_assertions u_sva (
	.i_clk(i_clk),
	.i_rst_n(i_rst_n),
	.i_cmd_valid(o_cmd_valid),
	.i_cmd_type(o_cmd_type),
	.i_uart_finish_wresp(o_uart_finish_wresp),
	.i_uart_finish_mrd(o_uart_finish_mrd),
	.i_dc_finish_wresp(o_dc_finish_wresp),
	.i_dc_finish_mrd(o_dc_finish_mrd)
);

// ==== verification/tb_fpga_sys.sv ====
// tb_fpga_sys
// directed testbench for fpga_sys_top
// line writes and reads from both masters against a reference line model
// plus contention, address wrap and the led registers

`timescale 1ns/100ps

module tb_fpga_sys;

localparam int MEM_AW = 6;
localparam int RD_LAT = 4;
localparam int LW = fpga_sys_pkg::LINE_W;
localparam int MW = fpga_sys_pkg::MASK_W;
localparam int AW = fpga_sys_pkg::ADDR_W;
localparam int IO_AW = fpga_sys_pkg::IO_AW;
localparam int IO_DW = fpga_sys_pkg::IO_DW;
localparam int LED_W = fpga_sys_pkg::LED_W;
localparam int WAIT_LIMIT = 3 * (RD_LAT + 4); // own request plus one queued ahead
localparam int NUM_OPS = 28; // memory and i/o operations below
localparam int CYCLE_LIMIT = NUM_OPS * (RD_LAT + 4) + 50; // margin for reset and gaps
localparam int FIN_UART_WR = 0;
localparam int FIN_UART_RD = 1;
localparam int FIN_DC_WR = 2;
localparam int FIN_DC_RD = 3;

logic clk;
logic rst_n;
logic i_uart_wstart_rq, i_uart_rstart_rq, i_dc_wstart_rq, i_dc_rstart_rq;
logic [AW-1:0] i_uart_win_addr, i_uart_rin_addr, i_dc_win_addr, i_dc_rin_addr;
logic [LW-1:0] i_uart_in_wdata, i_dc_in_wdata, o_uart_rdat_m_data, o_dc_rdat_m_data;
logic [MW-1:0] i_uart_in_mask, i_dc_in_mask;
logic o_uart_finish_wresp, o_uart_finish_mrd, o_uart_rdat_m_valid;
logic o_dc_finish_wresp, o_dc_finish_mrd, o_dc_rdat_m_valid, o_dc_rqfull;
logic i_dma_io_we;
logic [IO_AW-1:0] i_dma_io_wadr, i_dma_io_radr;
logic [IO_DW-1:0] i_dma_io_wdata, i_dma_io_rdata_in, o_dma_io_rdata;
logic [LED_W-1:0] o_rgb_led, o_rgb_led1, o_rgb_led2, o_rgb_led3;

logic [LW-1:0] ref_mem [0:(1<<MEM_AW)-1]; // reference lines
logic [LED_W-1:0] led_ref [0:3];
logic [31:0] lcg_state;
int err_value = 0;
int err_handshake = 0;
int cycle_count = 0;

fpga_sys_top #(.MEM_AW(MEM_AW), .RD_LAT(RD_LAT)) dut0 (
	.i_clk(clk), .i_rst_n(rst_n),
	.i_uart_wstart_rq(i_uart_wstart_rq), .i_uart_rstart_rq(i_uart_rstart_rq),
	.i_uart_win_addr(i_uart_win_addr), .i_uart_rin_addr(i_uart_rin_addr),
	.i_uart_in_wdata(i_uart_in_wdata), .i_uart_in_mask(i_uart_in_mask),
	.o_uart_finish_wresp(o_uart_finish_wresp), .o_uart_finish_mrd(o_uart_finish_mrd),
	.o_uart_rdat_m_valid(o_uart_rdat_m_valid), .o_uart_rdat_m_data(o_uart_rdat_m_data),
	.i_dc_wstart_rq(i_dc_wstart_rq), .i_dc_rstart_rq(i_dc_rstart_rq),
	.i_dc_win_addr(i_dc_win_addr), .i_dc_rin_addr(i_dc_rin_addr),
	.i_dc_in_wdata(i_dc_in_wdata), .i_dc_in_mask(i_dc_in_mask),
	.o_dc_finish_wresp(o_dc_finish_wresp), .o_dc_finish_mrd(o_dc_finish_mrd),
	.o_dc_rdat_m_valid(o_dc_rdat_m_valid), .o_dc_rdat_m_data(o_dc_rdat_m_data),
	.o_dc_rqfull(o_dc_rqfull),
	.i_dma_io_we(i_dma_io_we), .i_dma_io_wadr(i_dma_io_wadr),
	.i_dma_io_wdata(i_dma_io_wdata), .i_dma_io_radr(i_dma_io_radr),
	.i_dma_io_rdata_in(i_dma_io_rdata_in), .o_dma_io_rdata(o_dma_io_rdata),
	.o_rgb_led(o_rgb_led), .o_rgb_led1(o_rgb_led1),
	.o_rgb_led2(o_rgb_led2), .o_rgb_led3(o_rgb_led3)
);

always #20 clk = ~clk; // 40 ns period

always @(posedge clk) begin
	cycle_count++;
	if (cycle_count >= CYCLE_LIMIT) begin
		$display("run stopped: cycle limit of %0d reached before the tests ended", CYCLE_LIMIT);
		$display("TEST FAILED");
		$finish;
	end
end

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

function automatic logic [LW-1:0] rand_line();
	logic [LW-1:0] v;
	for (int w = 0; w < LW / 32; w++)
		v[w*32 +: 32] = lcg_next();
	return v;
endfunction

// line index above the byte offset with the upper bits wrapping
function automatic int line_of(input logic [AW-1:0] addr);
	return int'(addr[fpga_sys_pkg::LINE_OFS +: MEM_AW]);
endfunction

task automatic update_ref(input logic [AW-1:0] addr, input logic [LW-1:0] data,
	input logic [MW-1:0] mask);
	logic [LW-1:0] line;
	line = ref_mem[line_of(addr)];
	for (int b = 0; b < MW; b++)
		if (!mask[b])
			line[b*8 +: 8] = data[b*8 +: 8]; // clear bit writes the byte
	ref_mem[line_of(addr)] = line;
endtask

task automatic check_line(input logic [LW-1:0] got, input logic [LW-1:0] exp, input string what);
	if (got !== exp) begin
		err_value++;
		$display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
	end
endtask

task automatic check_led(input logic [LED_W-1:0] got, input logic [LED_W-1:0] exp,
	input string what);
	if (got !== exp) begin
		err_value++;
		$display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
	end
endtask

task automatic check_io(input logic [IO_DW-1:0] got, input logic [IO_DW-1:0] exp,
	input string what);
	if (got !== exp) begin
		err_value++;
		$display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
	end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		err_value++;
		$display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
	end
endtask

task automatic check_cycles(input int got, input int exp, input string what);
	if (got != exp) begin
		err_value++;
		$display("[FAIL] %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
	end
endtask

function automatic logic finish_of(input int sel);
	case (sel)
		FIN_UART_WR: return o_uart_finish_wresp;
		FIN_UART_RD: return o_uart_finish_mrd;
		FIN_DC_WR: return o_dc_finish_wresp;
		default: return o_dc_finish_mrd;
	endcase
endfunction

function automatic logic [LED_W-1:0] led_out(input int n);
	case (n)
		0: return o_rgb_led;
		1: return o_rgb_led1;
		2: return o_rgb_led2;
		default: return o_rgb_led3;
	endcase
endfunction

task automatic drop_strobes();
	i_uart_wstart_rq = 1'b0;
	i_uart_rstart_rq = 1'b0;
	i_dc_wstart_rq = 1'b0;
	i_dc_rstart_rq = 1'b0;
endtask

// drive one strobe and its fields, which stay held until the finish
task automatic issue(input int sel, input logic [AW-1:0] addr, input logic [LW-1:0] data,
	input logic [MW-1:0] mask);
	case (sel)
		FIN_UART_WR: begin
			i_uart_win_addr = addr;
			i_uart_in_wdata = data;
			i_uart_in_mask = mask;
			i_uart_wstart_rq = 1'b1;
		end
		FIN_UART_RD: begin
			i_uart_rin_addr = addr;
			i_uart_rstart_rq = 1'b1;
		end
		FIN_DC_WR: begin
			i_dc_win_addr = addr;
			i_dc_in_wdata = data;
			i_dc_in_mask = mask;
			i_dc_wstart_rq = 1'b1;
		end
		default: begin
			i_dc_rin_addr = addr;
			i_dc_rstart_rq = 1'b1;
		end
	endcase
endtask

task automatic wait_finish(input int sel, input string what, output int cycles, output bit seen);
	cycles = 0;
	seen = 1'b0;
	while (!seen && cycles < WAIT_LIMIT) begin
		@(negedge clk);
		drop_strobes();
		cycles++;
		seen = finish_of(sel);
	end
	if (!seen) begin
		err_handshake++;
		$display("%s: no finish pulse within %0d cycles at %0t", what, WAIT_LIMIT, $time);
	end
endtask

task automatic line_write(input int sel, input logic [AW-1:0] addr, input logic [LW-1:0] data,
	input logic [MW-1:0] mask, input string what);
	int cycles;
	bit seen;
	@(negedge clk);
	issue(sel, addr, data, mask);
	wait_finish(sel, what, cycles, seen);
	if (seen)
		check_cycles(cycles, 3, what);
	update_ref(addr, data, mask);
endtask

task automatic line_read(input int sel, input logic [AW-1:0] addr, input string what);
	int cycles;
	bit seen;
	@(negedge clk);
	issue(sel, addr, '0, '0);
	wait_finish(sel, what, cycles, seen);
	if (seen) begin
		check_cycles(cycles, RD_LAT + 1, what);
		check_flag(sel == FIN_DC_RD ? o_dc_rdat_m_valid : o_uart_rdat_m_valid, 1'b1, what);
		check_line(sel == FIN_DC_RD ? o_dc_rdat_m_data : o_uart_rdat_m_data,
			ref_mem[line_of(addr)], what);
	end
endtask

task automatic uart_write(input logic [AW-1:0] addr, input logic [LW-1:0] data,
	input logic [MW-1:0] mask);
	line_write(FIN_UART_WR, addr, data, mask, "uart write");
endtask

task automatic dc_write(input logic [AW-1:0] addr, input logic [LW-1:0] data,
	input logic [MW-1:0] mask);
	line_write(FIN_DC_WR, addr, data, mask, "dc write");
endtask

task automatic uart_read(input logic [AW-1:0] addr);
	line_read(FIN_UART_RD, addr, "uart read");
endtask

task automatic dc_read(input logic [AW-1:0] addr);
	line_read(FIN_DC_RD, addr, "dc read");
endtask

// both masters strobe in the same cycle and may be served in either order
task automatic contention(input bit is_write, input logic [AW-1:0] ua, input logic [AW-1:0] da);
	logic [LW-1:0] udata;
	logic [LW-1:0] ddata;
	bit u_done;
	bit d_done;
	int cycles;
	udata = rand_line();
	ddata = rand_line();
	u_done = 1'b0;
	d_done = 1'b0;
	cycles = 0;
	@(negedge clk);
	issue(is_write ? FIN_UART_WR : FIN_UART_RD, ua, udata, '0);
	issue(is_write ? FIN_DC_WR : FIN_DC_RD, da, ddata, '0);
	while (!(u_done && d_done) && cycles < WAIT_LIMIT) begin
		@(negedge clk);
		drop_strobes();
		cycles++;
		if (!d_done)
			check_flag(o_dc_rqfull, 1'b1, "dc rqfull while request open");
		if (!u_done && finish_of(is_write ? FIN_UART_WR : FIN_UART_RD)) begin
			u_done = 1'b1;
			if (!is_write)
				check_line(o_uart_rdat_m_data, ref_mem[line_of(ua)], "uart read, contention");
		end
		if (!d_done && finish_of(is_write ? FIN_DC_WR : FIN_DC_RD)) begin
			d_done = 1'b1;
			if (!is_write)
				check_line(o_dc_rdat_m_data, ref_mem[line_of(da)], "dc read, contention");
		end
	end
	if (!(u_done && d_done)) begin
		err_handshake++;
		$display("contention: uart done %0b, dc done %0b after %0d cycles", u_done, d_done, cycles);
	end
	if (is_write) begin
		update_ref(ua, udata, '0);
		update_ref(da, ddata, '0);
	end
	@(negedge clk);
	check_flag(o_dc_rqfull, 1'b0, "dc rqfull after finish");
endtask

task automatic io_write(input logic [IO_AW-1:0] adr, input logic [IO_DW-1:0] data);
	int n;
	n = int'(adr - fpga_sys_pkg::LED_BASE);
	@(negedge clk);
	i_dma_io_we = 1'b1;
	i_dma_io_wadr = adr;
	i_dma_io_wdata = data;
	@(negedge clk);
	i_dma_io_we = 1'b0;
	led_ref[n] = data[LED_W-1:0];
	check_led(led_out(n), led_ref[n], "led output after write");
endtask

task automatic io_read(input logic [IO_AW-1:0] adr, input logic [IO_DW-1:0] exp);
	@(negedge clk);
	i_dma_io_radr = adr;
	@(negedge clk);
	check_io(o_dma_io_rdata, exp, "i/o readback");
endtask

initial begin
	int total;
	lcg_state = 32'd23;
	clk = 1'b0;
	rst_n = 1'b0;
	drop_strobes();
	i_uart_win_addr = '0;
	i_uart_rin_addr = '0;
	i_uart_in_wdata = '0;
	i_uart_in_mask = '0;
	i_dc_win_addr = '0;
	i_dc_rin_addr = '0;
	i_dc_in_wdata = '0;
	i_dc_in_mask = '0;
	i_dma_io_we = 1'b0;
	i_dma_io_wadr = '0;
	i_dma_io_wdata = '0;
	i_dma_io_radr = '0;
	i_dma_io_rdata_in = 32'h5a5a_a5a5; // chain data that a window read must not return
	repeat (4) @(negedge clk);
	rst_n = 1'b1;

	// reset state
	check_flag(o_dc_rqfull, 1'b0, "dc rqfull after reset");
	check_flag(dut0.cmd_valid, 1'b0, "cmd_valid after reset");
	for (int n = 0; n < 4; n++) begin
		check_led(led_out(n), '0, "led after reset");
		io_read(IO_AW'(fpga_sys_pkg::LED_BASE + n), '0);
	end

	uart_write(32'h0000_0120, rand_line(), '0); // full line
	uart_read(32'h0000_0120);
	dc_write(32'h0000_0a40, rand_line(), '0);
	dc_write(32'h0000_0a40, rand_line(), MW'(lcg_next())); // masked merge
	dc_read(32'h0000_0a40);
	contention(1'b1, 32'h0000_0200, 32'h0000_0310);
	contention(1'b0, 32'h0000_0200, 32'h0000_0310);
	dc_write(32'h0000_0050, rand_line(), '0); // shared line
	uart_read(32'h0000_0050);
	uart_read(32'h0000_0450); // aliases line 5
	uart_write(32'h8000_0058, rand_line(), MW'(lcg_next()));
	dc_read(32'h0000_0050);

	for (int n = 0; n < 4; n++)
		io_write(IO_AW'(fpga_sys_pkg::LED_BASE + n), lcg_next());
	for (int n = 0; n < 4; n++)
		io_read(IO_AW'(fpga_sys_pkg::LED_BASE + n), IO_DW'(led_ref[n]));
	i_dma_io_rdata_in = lcg_next(); // chain data from further blocks
	io_read(IO_AW'(fpga_sys_pkg::LED_BASE + 4), i_dma_io_rdata_in);
	i_dma_io_rdata_in = lcg_next();
	io_read(14'h0010, i_dma_io_rdata_in);

	total = err_value + err_handshake + dut0.u_arb.u_sva.fail_count;
	$display("error counts: value %0d, handshake %0d, assertion %0d",
		err_value, err_handshake, dut0.u_arb.u_sva.fail_count);
	if (total == 0)
		$display("TEST PASSED");
	else
		$display("TEST FAILED");
	$finish;
end

endmodule

// ==== src.f ====
common/fpga_sys_pkg.sv
hw/axi_bus/bus_arbiter.sv
hw/dram/line_mem_ctrl.sv
hw/io_led.sv
hw/fpga_sys_top.sv
verification/fpga_sys_assertions.sv
verification/tb_fpga_sys.sv
